/* Bender.yml */
package:
  name: beeb_mem

sources:
  - beeb_mem_pkg.sv
  - beeb_rom_map.sv
  - beeb_cpu_port.sv
  - beeb_rom_loader.sv
  - beeb_bus_arbiter.sv
  - beeb_mem_store.sv
  - beeb_mem_top.sv
  - target: simulation
    files:
      - beeb_mem_assertions.sv
      - tb_beeb_mem.sv

/* beeb_bus_arbiter.sv */
`timescale 1ns/1ns

module beeb_bus_arbiter (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  beeb_mem_pkg::wb_req_t ld_req,
	input  beeb_mem_pkg::wb_req_t cpu_req,
	output beeb_mem_pkg::wb_rsp_t ld_rsp,
	output beeb_mem_pkg::wb_rsp_t cpu_rsp,
	output beeb_mem_pkg::wb_req_t mem_req,
	input  beeb_mem_pkg::wb_rsp_t mem_rsp
);

	// grant owner, both low when the bus is free
	logic gnt_ld;
	logic gnt_cpu;

	// ================================================
	// grant
	// ================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			gnt_ld  <= 1'b0;
			gnt_cpu <= 1'b0;
		end else if (gnt_ld || gnt_cpu) begin
			// release on the owner's ack
			if (mem_rsp.ack) begin
				gnt_ld  <= 1'b0;
				gnt_cpu <= 1'b0;
			end
		end else if (ld_req.cyc) begin
			// loader wins over the core
			gnt_ld <= 1'b1;
		end else if (cpu_req.cyc) begin
			gnt_cpu <= 1'b1;
		end
	end

	// ================================================
	// steering
	// ================================================

	always_comb begin
		mem_req = '0;
		if (gnt_ld)
			mem_req = ld_req;
		else if (gnt_cpu)
			mem_req = cpu_req;
	end

	// the waiting master sees nothing
	assign ld_rsp  = gnt_ld ? mem_rsp : '0;
	assign cpu_rsp = gnt_cpu ? mem_rsp : '0;

endmodule

/* beeb_cpu_port.sv */
`timescale 1ns/1ns

module beeb_cpu_port (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    model_latch,
	input  logic                    model_m128,
	input  logic                    cpu_req,
	input  logic                    cpu_we,
	input  beeb_mem_pkg::cpu_addr_t cpu_addr,
	input  beeb_mem_pkg::byte_t     cpu_wdata,
	output logic                    cpu_ack,
	output beeb_mem_pkg::byte_t     cpu_rdata,
	output beeb_mem_pkg::wb_req_t   wb_req,
	input  beeb_mem_pkg::wb_rsp_t   wb_rsp
);
	import beeb_mem_pkg::*;

	cpu_port_state_t state;
	logic            model_q;
	rom_slot_t       slot;
	logic            mapped;
	logic            start;
	logic            answer_local;
	phys_addr_t      phys_addr;
	phys_addr_t      adr_q;
	logic            we_q;
	bus_data_t       dat_q;
	byte_sel_t       sel_q;
	byte_t           rdata_q;
	byte_t           bus_byte;

	beeb_rom_map u_rom_map (
		.model_m128 (model_q),
		.bank       (cpu_addr[17:14]),
		.slot       (slot),
		.mapped     (mapped)
	);

	// new request, ignoring the cycle where the core still sees our ack
	assign start = cpu_req & ~cpu_ack;
	// empty rom banks and rom writes never reach the bus
	assign answer_local = ~cpu_addr[18] & (cpu_we | ~mapped);
	assign phys_addr = cpu_addr[18] ? phys_addr_t'(cpu_addr) : {1'b0, slot, cpu_addr[13:0]};

	// ram and odd rom bytes sit in the low lane
	assign bus_byte = (adr_q[18] | adr_q[0]) ? wb_rsp.dat[7:0] : wb_rsp.dat[15:8];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= cpu_idle;
			cpu_ack <= 1'b0;
			model_q <= 1'b0;
		end else begin
			cpu_ack <= 1'b0;
			// model only moves on the core's reset request
			if (model_latch)
				model_q <= model_m128;
			case (state)
				cpu_idle:
					if (start)
						state <= answer_local ? cpu_reply : cpu_bus;
				cpu_bus:
					if (wb_rsp.ack)
						state <= cpu_reply;
				default: begin
					// one cycle ack pulse back to the core
					cpu_ack <= 1'b1;
					state   <= cpu_idle;
				end
			endcase
		end
	end

	// request fields and read byte
	always_ff @(posedge clk_sys) begin
		if (state == cpu_idle && start) begin
			adr_q   <= phys_addr;
			we_q    <= cpu_we;
			dat_q   <= {8'h00, cpu_wdata};
			sel_q   <= cpu_addr[18] ? 2'b01 : 2'b11;
			rdata_q <= bank_unmapped_data;
		end
		if (state == cpu_bus && wb_rsp.ack)
			rdata_q <= bus_byte;
	end

	assign cpu_rdata = rdata_q;
	assign wb_req = '{cyc: state == cpu_bus, stb: state == cpu_bus, we: we_q,
		adr: adr_q, dat: dat_q, sel: sel_q};

endmodule

/* beeb_mem_assertions.sv */
`timescale 1ns/1ns

module beeb_mem_assertions (
	input logic                  clk_sys,
	input logic                  rst_n,
	input logic                  cpu_req,
	input logic                  cpu_ack,
	input beeb_mem_pkg::wb_req_t ld_req,
	input beeb_mem_pkg::wb_rsp_t ld_rsp,
	input beeb_mem_pkg::wb_req_t cpu_wb_req,
	input beeb_mem_pkg::wb_rsp_t cpu_wb_rsp,
	input beeb_mem_pkg::wb_req_t mem_req,
	input beeb_mem_pkg::wb_rsp_t mem_rsp
);

	// read back by the testbench for the verdict
	int fail_count = 0;

	// ================================================
	// shared bus
	// ================================================

	// store ack only inside a live cycle
	store_ack_in_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_rsp.ack |-> mem_req.cyc && mem_req.stb)
		else begin
			fail_count++;
			$error("store ack raised without cyc and stb");
		end

	// fields frozen while waiting whether granted or not
	loader_req_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ld_req.cyc && !ld_rsp.ack) |=> $stable(ld_req))
		else begin
			fail_count++;
			$error("loader request changed before its ack");
		end

	cpu_req_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(cpu_wb_req.cyc && !cpu_wb_rsp.ack) |=> $stable(cpu_wb_req))
		else begin
			fail_count++;
			$error("cpu port request changed before its ack");
		end

	// ================================================
	// core handshake
	// ================================================

	cpu_ack_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cpu_ack |-> cpu_req ##1 !cpu_ack)
		else begin
			fail_count++;
			$error("cpu_ack longer than one cycle or without cpu_req");
		end

endmodule

/* beeb_mem_pkg.sv */
package beeb_mem_pkg;

	// ================================================
	// memory sizes
	// ================================================

	// sideways rom slots, model b and master images together
	localparam int rom_slot_count = 14;
	localparam int rom_slot_bytes = 16384;
	// rom store is organised as 16-bit words
	localparam int rom_words = rom_slot_count * rom_slot_bytes / 2;
	// ram window behind address bit 18
	localparam int ram_bytes = 212992;

	// ================================================
	// address and data types
	// ================================================

	// core address: [18] ram, [17:14] bank, [13:0] offset
	typedef logic [18:0] cpu_addr_t;
	// bus byte address: [18] ram, else slot * 16k + offset
	typedef logic [18:0] phys_addr_t;
	typedef logic [3:0]  rom_slot_t;
	typedef logic [15:0] bus_data_t;
	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  byte_sel_t;

	// byte seen by the core on an empty bank
	localparam byte_t bank_unmapped_data = 8'h00;

	// ================================================
	// wishbone classic
	// ================================================

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		phys_addr_t adr;
		bus_data_t  dat;
		// bit 0 low lane, bit 1 high lane
		byte_sel_t  sel;
	} wb_req_t;

	typedef struct packed {
		logic      ack;
		bus_data_t dat;
	} wb_rsp_t;

	// fsm states
	typedef enum logic [1:0] {cpu_idle, cpu_bus, cpu_reply} cpu_port_state_t;
	typedef enum logic {ld_idle, ld_write} loader_state_t;

endpackage

/* beeb_mem_store.sv */
`timescale 1ns/1ns

module beeb_mem_store (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  beeb_mem_pkg::wb_req_t mem_req,
	output beeb_mem_pkg::wb_rsp_t mem_rsp
);
	import beeb_mem_pkg::*;

	// ================================================
	// arrays
	// ================================================

	// rom images, one word holds an even and odd byte pair
	bus_data_t rom_mem [0:rom_words-1];
	// ram window, byte wide
	byte_t     ram_mem [0:ram_bytes-1];

	logic        ack_q;
	bus_data_t   rd_q;
	logic        hit;
	logic        is_ram;
	logic [16:0] rom_idx;
	logic [17:0] ram_idx;

	// one ack per cycle, so a held request is not served twice
	assign hit = mem_req.cyc & mem_req.stb & ~ack_q;
	assign is_ram = mem_req.adr[18];
	assign rom_idx = mem_req.adr[17:1];
	assign ram_idx = mem_req.adr[17:0];

	// ================================================
	// access
	// ================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= hit;
	end

	always_ff @(posedge clk_sys) begin
		if (hit) begin
			// rom takes whole words only
			if (mem_req.we && !is_ram && mem_req.sel == 2'b11)
				rom_mem[rom_idx] <= mem_req.dat;
			// ram byte comes from the low lane
			if (mem_req.we && is_ram && mem_req.sel[0])
				ram_mem[ram_idx] <= mem_req.dat[7:0];
			// registered read, ram byte in the low lane
			if (is_ram)
				rd_q <= {8'h00, ram_mem[ram_idx]};
			else
				rd_q <= rom_mem[rom_idx];
		end
	end

	assign mem_rsp = '{ack: ack_q, dat: rd_q};

endmodule

/* beeb_mem_top.sv */
`timescale 1ns/1ns

module beeb_mem_top (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     model_latch,
	input  logic                     model_m128,
	input  logic                     cpu_req,
	input  logic                     cpu_we,
	input  beeb_mem_pkg::cpu_addr_t  cpu_addr,
	input  beeb_mem_pkg::byte_t      cpu_wdata,
	output logic                     cpu_ack,
	output beeb_mem_pkg::byte_t      cpu_rdata,
	input  logic                     load_valid,
	input  beeb_mem_pkg::phys_addr_t load_addr,
	input  beeb_mem_pkg::bus_data_t  load_data,
	output logic                     load_ready
);
	import beeb_mem_pkg::*;

	// master side of the arbiter
	wb_req_t ld_wb_req;
	wb_rsp_t ld_wb_rsp;
	wb_req_t cpu_wb_req;
	wb_rsp_t cpu_wb_rsp;
	// store side
	wb_req_t mem_req;
	wb_rsp_t mem_rsp;

	beeb_cpu_port u_cpu_port (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.model_latch (model_latch),
		.model_m128  (model_m128),
		.cpu_req     (cpu_req),
		.cpu_we      (cpu_we),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_ack     (cpu_ack),
		.cpu_rdata   (cpu_rdata),
		.wb_req      (cpu_wb_req),
		.wb_rsp      (cpu_wb_rsp)
	);

	beeb_rom_loader u_rom_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.load_valid (load_valid),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_ready (load_ready),
		.wb_req     (ld_wb_req),
		.wb_rsp     (ld_wb_rsp)
	);

	beeb_bus_arbiter u_bus_arbiter (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ld_req  (ld_wb_req),
		.cpu_req (cpu_wb_req),
		.ld_rsp  (ld_wb_rsp),
		.cpu_rsp (cpu_wb_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	beeb_mem_store u_mem_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

/* beeb_rom_loader.sv */
`timescale 1ns/1ns

module beeb_rom_loader (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     load_valid,
	input  beeb_mem_pkg::phys_addr_t load_addr,
	input  beeb_mem_pkg::bus_data_t  load_data,
	output logic                     load_ready,
	output beeb_mem_pkg::wb_req_t    wb_req
	, input beeb_mem_pkg::wb_rsp_t   wb_rsp
);
	import beeb_mem_pkg::*;

	loader_state_t state;
	phys_addr_t    adr_q;
	bus_data_t     dat_q;
	logic          take;

	// accept only while no write is outstanding
	assign load_ready = (state == ld_idle);
	assign take = load_valid & load_ready;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			state <= ld_idle;
		else if (take)
			state <= ld_write;
		else if (state == ld_write && wb_rsp.ack)
			state <= ld_idle;
	end

	// image bytes arrive swapped relative to the store word
	// low input byte ends up at the even address
	always_ff @(posedge clk_sys) begin
		if (take) begin
			adr_q <= {1'b0, load_addr[17:0]};
			dat_q <= {load_data[7:0], load_data[15:8]};
		end
	end

	// full word write, both lanes
	assign wb_req = '{cyc: state == ld_write, stb: state == ld_write, we: 1'b1,
		adr: adr_q, dat: dat_q, sel: 2'b11};

endmodule

/* beeb_rom_map.sv */
`timescale 1ns/1ns

module beeb_rom_map (
	input  logic                   model_m128,
	input  beeb_mem_pkg::rom_slot_t bank,
	output beeb_mem_pkg::rom_slot_t slot,
	output logic                   mapped
);

	// sideways bank to physical slot
	// slots 0..3 hold the model b images, 4..13 the master ones
	always_comb begin
		slot   = 4'd0;
		mapped = 1'b1;
		case ({model_m128, bank})
			// model b: os, filing system, ram master, basic
			5'b0_0100: slot = 4'd0;
			5'b0_1000: slot = 4'd1;
			5'b0_1110: slot = 4'd2;
			5'b0_1111: slot = 4'd3;
			// master: adfs, mmfs, mos
			5'b1_0010: slot = 4'd4;
			5'b1_0011: slot = 4'd5;
			5'b1_0100: slot = 4'd6;
			// dfs, viewsheet, edit
			5'b1_1001: slot = 4'd7;
			5'b1_1010: slot = 4'd8;
			5'b1_1011: slot = 4'd9;
			// basic 4, adfs, view, terminal
			5'b1_1100: slot = 4'd10;
			5'b1_1101: slot = 4'd11;
			5'b1_1110: slot = 4'd12;
			5'b1_1111: slot = 4'd13;
			default: begin
				// empty bank, reads come back as zero
				slot   = 4'd0;
				mapped = 1'b0;
			end
		endcase
	end

endmodule

/* tb_beeb_mem.sv */
`timescale 1ns/1ns

module tb_beeb_mem;
	import beeb_mem_pkg::*;

	localparam int clk_period = 100;
	localparam logic [15:0] lfsr_seed = 16'd4;
	localparam int words_per_slot = 4;
	localparam int reload_words = 16;
	localparam int ram_ops = 12;
	localparam int rom_write_ops = 4;
	// loads, three bank sweeps, rom writes with read-back, ram writes with read-back
	localparam int txn_count = rom_slot_count * words_per_slot + reload_words
		+ 3 * 32 + 2 * rom_write_ops + 2 * ram_ops;
	localparam int watchdog_cycles = txn_count * 20 + 200;
	// sideways banks in slot order for each model
	localparam int model_b_banks [4] = '{4, 8, 14, 15};
	localparam int master_banks [10] = '{2, 3, 4, 9, 10, 11, 12, 13, 14, 15};

	logic       clk_sys;
	logic       rst_n;
	logic       model_latch;
	logic       model_m128;
	logic       cpu_req;
	logic       cpu_we;
	cpu_addr_t  cpu_addr;
	byte_t      cpu_wdata;
	logic       cpu_ack;
	byte_t      cpu_rdata;
	logic       load_valid;
	phys_addr_t load_addr;
	bus_data_t  load_data;
	logic       load_ready;

	// reference model with one byte per physical address
	byte_t       rom_ref [int];
	byte_t       ram_ref [int];
	int          word_off [rom_slot_count][words_per_slot];
	logic [15:0] lfsr_state;
	logic        check_read;
	byte_t       exp_rdata;
	int          data_errors = 0;
	int          load_errors = 0;

	beeb_mem_top u_beeb_mem_top (.*);

	bind beeb_mem_top beeb_mem_assertions u_mem_assertions (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cpu_req    (cpu_req),
		.cpu_ack    (cpu_ack),
		.ld_req     (ld_wb_req),
		.ld_rsp     (ld_wb_rsp),
		.cpu_wb_req (cpu_wb_req),
		.cpu_wb_rsp (cpu_wb_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// ================================================
	// checks
	// ================================================

	read_data_check: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(cpu_ack && check_read) |-> (cpu_rdata == exp_rdata))
		else begin
			data_errors++;
			$display("[FAIL] %0t ns cpu_rdata got %02h expected %02h",
				$time, $sampled(cpu_rdata), $sampled(exp_rdata));
		end

	// back-pressure right after each accepted word
	load_ready_drop: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(load_valid && load_ready) |=> !load_ready)
		else begin
			load_errors++;
			$display("[FAIL] %0t ns load_ready got %0b expected 0",
				$time, $sampled(load_ready));
		end

	// ================================================
	// helpers
	// ================================================

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// physical slot of a bank or -1 when empty
	function automatic int slot_for(input logic m128, input int bank);
		slot_for = -1;
		if (!m128) begin
			for (int i = 0; i < 4; i++)
				if (model_b_banks[i] == bank)
					slot_for = i;
		end else begin
			for (int i = 0; i < 10; i++)
				if (master_banks[i] == bank)
					slot_for = 4 + i;
		end
	endfunction

	// entered and left 10 ns after an edge
	task automatic cpu_access(input logic we, input cpu_addr_t addr, input byte_t wdata,
		input logic chk, input byte_t exp);
		cpu_req = 1'b1;
		cpu_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
		check_read = chk;
		exp_rdata = exp;
		do begin
			@(posedge clk_sys);
			#10;
		end while (!cpu_ack);
		// held through the ack cycle
		@(posedge clk_sys);
		#10;
		cpu_req = 1'b0;
		check_read = 1'b0;
		@(posedge clk_sys);
		#10;
	endtask

	task automatic load_word(input phys_addr_t addr, input bus_data_t data);
		load_valid = 1'b1;
		load_addr = addr;
		load_data = data;
		while (!load_ready) begin
			@(posedge clk_sys);
			#10;
		end
		@(posedge clk_sys);
		#10;
		load_valid = 1'b0;
		// low input byte is the even address byte
		rom_ref[int'({addr[17:1], 1'b0})] = data[7:0];
		rom_ref[int'({addr[17:1], 1'b1})] = data[15:8];
	endtask

	task automatic latch_model(input logic m128);
		model_m128 = m128;
		model_latch = 1'b1;
		@(posedge clk_sys);
		#10;
		model_latch = 1'b0;
	endtask

	// random byte of a loaded word
	task automatic rom_read(input int bank, input int slot);
		int off;
		off = word_off[slot][rand_bits(2)] * 2 + rand_bits(1);
		cpu_access(1'b0, {1'b0, 4'(bank), 14'(off)}, 8'h00, 1'b1,
			rom_ref[slot * rom_slot_bytes + off]);
	endtask

	// all sixteen banks where empty ones read as zero
	task automatic sweep_banks(input logic m128);
		int slot;
		for (int b = 0; b < 16; b++) begin
			slot = slot_for(m128, b);
			if (slot < 0) begin
				cpu_access(1'b0, {1'b0, 4'(b), 14'(rand_bits(14))}, 8'h00, 1'b1, 8'h00);
			end else begin
				rom_read(b, slot);
				rom_read(b, slot);
			end
		end
	endtask

	// ================================================
	// stimulus
	// ================================================

	initial begin
		int          b;
		int          slot;
		int          off;
		int          total;
		byte_t       wdata;
		logic [16:0] ram_addr [ram_ops];
		phys_addr_t  reload_addr [reload_words];
		bus_data_t   reload_data [reload_words];
		lfsr_state = lfsr_seed;
		rst_n = 1'b0;
		model_latch = 1'b0;
		model_m128 = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		check_read = 1'b0;
		exp_rdata = '0;
		repeat (4) @(posedge clk_sys);
		#10;
		rst_n = 1'b1;

		// fill every slot of both models
		for (int s = 0; s < rom_slot_count; s++) begin
			for (int k = 0; k < words_per_slot; k++) begin
				word_off[s][k] = rand_bits(13);
				load_word(phys_addr_t'(s * rom_slot_bytes + word_off[s][k] * 2),
					bus_data_t'(rand_bits(16)));
			end
		end

		latch_model(1'b0);
		sweep_banks(1'b0);
		latch_model(1'b1);
		sweep_banks(1'b1);
		// model input moves without a latch pulse
		model_m128 = 1'b0;
		sweep_banks(1'b1);

		// rom writes are dropped
		for (int i = 0; i < rom_write_ops; i++) begin
			b = master_banks[rand_bits(3)];
			slot = slot_for(1'b1, b);
			off = word_off[slot][rand_bits(2)] * 2 + rand_bits(1);
			cpu_access(1'b1, {1'b0, 4'(b), 14'(off)}, byte_t'(rand_bits(8)), 1'b0, 8'h00);
			cpu_access(1'b0, {1'b0, 4'(b), 14'(off)}, 8'h00, 1'b1,
				rom_ref[slot * rom_slot_bytes + off]);
		end

		// loader words drawn up front so the lfsr stays with the ram branch
		for (int i = 0; i < reload_words; i++) begin
			slot = rand_bits(4) % rom_slot_count;
			off = word_off[slot][rand_bits(2)] * 2;
			reload_addr[i] = phys_addr_t'(slot * rom_slot_bytes + off);
			reload_data[i] = bus_data_t'(rand_bits(16));
		end

		// ram traffic against a loader stream
		fork
			begin
				for (int i = 0; i < reload_words; i++)
					load_word(reload_addr[i], reload_data[i]);
			end
			begin
				for (int i = 0; i < ram_ops; i++) begin
					ram_addr[i] = rand_bits(17);
					wdata = rand_bits(8);
					cpu_access(1'b1, {2'b10, ram_addr[i]}, wdata, 1'b0, 8'h00);
					ram_ref[int'(ram_addr[i])] = wdata;
				end
				for (int i = 0; i < ram_ops; i++)
					cpu_access(1'b0, {2'b10, ram_addr[i]}, 8'h00, 1'b1,
						ram_ref[int'(ram_addr[i])]);
			end
		join

		repeat (4) @(posedge clk_sys);
		total = data_errors + load_errors + u_beeb_mem_top.u_mem_assertions.fail_count;
		$display("errors: read data %0d, load handshake %0d, bus protocol %0d",
			data_errors, load_errors, u_beeb_mem_top.u_mem_assertions.fail_count);
		if (total == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// hang guard
	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("watchdog expired, a transaction never completed");
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* verilog.f */
beeb_mem_pkg.sv
beeb_rom_map.sv
beeb_cpu_port.sv
beeb_rom_loader.sv
beeb_bus_arbiter.sv
beeb_mem_store.sv
beeb_mem_top.sv
beeb_mem_assertions.sv
tb_beeb_mem.sv
